// ==== Makefile ====
# Verilator lint and simulation of the write guard

VERILATOR  ?= verilator
TOP        := write_guard_tb
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --assert -j 0 -Wno-fatal --Mdir $(OBJ_DIR)
PASS_MSG   := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The grep result is the status of the target
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== list.f ====
verilog/guard_cfg_pkg.sv
verilog/guard_types_pkg.sv
verilog/txn_tbl_if.sv
verilog/guard_prescaler.sv
verilog/id_match_unit.sv
verilog/txn_table.sv
verilog/write_guard_ctrl.sv
verilog/write_guard_top.sv
verif/write_guard_checker.sv
verif/write_guard_tb.sv

// ==== verif/write_guard_checker.sv ====
// Write guard assertions, bound into write_guard_top
// Interrupt pulse width, count bound, table flush after a reset request

`timescale 1ns/1ps
`default_nettype none

module write_guard_checker #(
  parameter int unsigned MaxWrTxns = guard_cfg_pkg::DefaultMaxWrTxns
) (
  input logic                             clk_i,
  input logic                             rst_n_i,
  input logic                             irq_i,
  input logic                             reset_req_i,
  input logic [$clog2(MaxWrTxns + 1)-1:0] txn_count_i
);

  // Sticky flags, read by the testbench
  logic irq_fail   = 1'b0;
  logic count_fail = 1'b0;
  logic flush_fail = 1'b0;
  logic any_fail;

  assign any_fail = irq_fail | count_fail | flush_fail;

  irq_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_i |=> !irq_i)
    else begin
      irq_fail = 1'b1;
      $error("irq_o high for two consecutive cycles");
    end

  count_bound_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    txn_count_i <= MaxWrTxns)
    else begin
      count_fail = 1'b1;
      $error("txn_count_o above table depth");
    end

  // Table flushed in the cycle the request rises
  flush_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(reset_req_i) |=> (txn_count_i == '0))
    else begin
      flush_fail = 1'b1;
      $error("txn_count_o not zero one cycle after reset_req_o rose");
    end

endmodule

bind write_guard_top write_guard_checker #(
  .MaxWrTxns ( MaxWrTxns )
) i_checker (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .irq_i       ( irq_o       ),
  .reset_req_i ( reset_req_o ),
  .txn_count_i ( txn_count_o )
);

`default_nettype wire

// ==== verif/write_guard_tb.sv ====
// Write guard testbench
// Clock and reset, stimulus table applied in a loop, value checks, cycle limit

`timescale 1ns/1ps
`default_nettype none

module write_guard_tb;

  localparam int unsigned MaxWrTxns    = 4;
  localparam int unsigned PrescalerDiv = 2;
  localparam int unsigned CntWidth     = 6;
  localparam int unsigned CountWidth   = $clog2(MaxWrTxns + 1);
  localparam int          ClkHalf      = 50;
  localparam int          ResetCycles  = 16;
  localparam int          Budget       = 7;
  localparam int          LongLen      = 99;   // 58 ticks, outlives any short sequence
  localparam int          CycleSlack   = 200;

  typedef enum logic [2:0] {
    ROW_AW, ROW_B, ROW_IDLE, ROW_CLEAR, ROW_TIMEOUT, ROW_SURVIVE
  } row_kind_e;

  typedef struct packed {
    row_kind_e             kind;
    guard_types_pkg::id_t  id;
    guard_types_pkg::len_t len;
    logic                  wr_en;
    logic [7:0]            wait_cyc;
    logic [CountWidth-1:0] exp_count;
    logic                  exp_reset;
  } stim_row_t;

  logic                     clk;
  logic                     rst_n;
  logic                     wr_en;
  logic                     aw_valid;
  logic                     aw_ready;
  guard_types_pkg::id_t     aw_id;
  guard_types_pkg::len_t    aw_len;
  logic                     b_valid;
  logic                     b_ready;
  guard_types_pkg::id_t     b_id;
  guard_types_pkg::budget_t budget;
  logic                     reset_clear;
  logic                     reset_req;
  logic                     irq;
  logic [CountWidth-1:0]    txn_count;

  stim_row_t rows[$];
  int        cycle_cnt;
  int        cycle_limit;
  int        acc_cycle;     // Cycle of the last AW edge
  int        irq_seen;
  int        timeouts_exp;

  write_guard_top #(
    .MaxWrTxns    ( MaxWrTxns    ),
    .PrescalerDiv ( PrescalerDiv ),
    .CntWidth     ( CntWidth     )
  ) uut (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .wr_en_i       ( wr_en       ),
    .aw_valid_i    ( aw_valid    ),
    .aw_ready_i    ( aw_ready    ),
    .aw_id_i       ( aw_id       ),
    .aw_len_i      ( aw_len      ),
    .b_valid_i     ( b_valid     ),
    .b_ready_i     ( b_ready     ),
    .b_id_i        ( b_id        ),
    .budget_i      ( budget      ),
    .reset_clear_i ( reset_clear ),
    .reset_req_o   ( reset_req   ),
    .irq_o         ( irq         ),
    .txn_count_o   ( txn_count   )
  );

  always #ClkHalf clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      abort_run("Simulation ran past its cycle limit without finishing");
    end
  end

  always @(negedge clk) begin
    if (irq === 1'b1) begin
      irq_seen <= irq_seen + 1;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s expected %0d, got %0d", $time, what, expected, actual);
      abort_run("Stopping at the first mismatch");
    end
  endtask

  // Age limit in ticks from budget, burst length and prescaler
  function automatic int limit_ticks(input int len);
    return Budget + ((len + 1) >> $clog2(PrescalerDiv)) + 1;
  endfunction

  task automatic add_row(input row_kind_e kind, input int id, input int len,
                         input logic en, input int wait_cyc, input int exp_count,
                         input logic exp_reset);
    stim_row_t r;
    r.kind      = kind;
    r.id        = guard_types_pkg::id_t'(id);
    r.len       = guard_types_pkg::len_t'(len);
    r.wr_en     = en;
    r.wait_cyc  = 8'(wait_cyc);
    r.exp_count = CountWidth'(exp_count);
    r.exp_reset = exp_reset;
    rows.push_back(r);
  endtask

  task automatic build_table();
    //      kind         id  len      en    wait cnt rst
    add_row(ROW_IDLE,    0,  0,       1'b1, 2,   0,  1'b0);
    // Count up and down, wr_en low and unknown B
    add_row(ROW_AW,      1,  LongLen, 1'b1, 1,   1,  1'b0);
    add_row(ROW_AW,      2,  LongLen, 1'b1, 1,   2,  1'b0);
    add_row(ROW_AW,      3,  LongLen, 1'b0, 1,   2,  1'b0);
    add_row(ROW_B,       1,  0,       1'b1, 1,   1,  1'b0);
    add_row(ROW_B,       9,  0,       1'b1, 1,   1,  1'b0);
    add_row(ROW_B,       2,  0,       1'b1, 1,   0,  1'b0);
    // Full table
    add_row(ROW_AW,      1,  LongLen, 1'b1, 1,   1,  1'b0);
    add_row(ROW_AW,      2,  LongLen, 1'b1, 1,   2,  1'b0);
    add_row(ROW_AW,      3,  LongLen, 1'b1, 1,   3,  1'b0);
    add_row(ROW_AW,      4,  LongLen, 1'b1, 1,   4,  1'b0);
    add_row(ROW_AW,      5,  LongLen, 1'b1, 1,   4,  1'b0);
    add_row(ROW_B,       1,  0,       1'b1, 1,   3,  1'b0);
    add_row(ROW_AW,      6,  LongLen, 1'b1, 1,   4,  1'b0);
    add_row(ROW_B,       5,  0,       1'b1, 1,   4,  1'b0);
    add_row(ROW_B,       2,  0,       1'b1, 1,   3,  1'b0);
    add_row(ROW_B,       3,  0,       1'b1, 1,   2,  1'b0);
    add_row(ROW_B,       4,  0,       1'b1, 1,   1,  1'b0);
    add_row(ROW_B,       6,  0,       1'b1, 1,   0,  1'b0);
    // Missing response
    add_row(ROW_AW,      7,  0,       1'b1, 1,   1,  1'b0);
    add_row(ROW_TIMEOUT, 0,  0,       1'b1, 2,   0,  1'b1);
    // Bus ignored until cleared
    add_row(ROW_AW,      8,  0,       1'b1, 1,   0,  1'b1);
    add_row(ROW_B,       7,  0,       1'b1, 1,   0,  1'b1);
    add_row(ROW_CLEAR,   0,  0,       1'b1, 0,   0,  1'b0);
    add_row(ROW_AW,      8,  LongLen, 1'b1, 1,   1,  1'b0);
    add_row(ROW_B,       8,  0,       1'b1, 1,   0,  1'b0);
    // Longer burst outlives the zero-length window
    add_row(ROW_AW,      9,  31,      1'b1, 1,   1,  1'b0);
    add_row(ROW_SURVIVE, 0,  0,       1'b1, 0,   1,  1'b0);
    add_row(ROW_TIMEOUT, 0,  31,      1'b1, 2,   0,  1'b1);
    add_row(ROW_CLEAR,   0,  0,       1'b1, 1,   0,  1'b0);
    add_row(ROW_IDLE,    0,  0,       1'b1, 2,   0,  1'b0);
  endtask

  task automatic drive_aw(input stim_row_t r);
    @(posedge clk);
    aw_valid <= 1'b1;
    aw_ready <= 1'b1;
    aw_id    <= r.id;
    aw_len   <= r.len;
    wr_en    <= r.wr_en;
    @(posedge clk);
    aw_valid <= 1'b0;
    aw_ready <= 1'b0;
    wr_en    <= 1'b1;
  endtask

  task automatic drive_b(input stim_row_t r);
    @(posedge clk);
    b_valid <= 1'b1;
    b_ready <= 1'b1;
    b_id    <= r.id;
    @(posedge clk);
    b_valid <= 1'b0;
    b_ready <= 1'b0;
  endtask

  task automatic drive_clear();
    @(posedge clk);
    reset_clear <= 1'b1;
    @(posedge clk);
    reset_clear <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic apply_row(input stim_row_t r);
    int   gap;
    int   lim;
    int   lo;
    int   hi;
    logic seen;
    case (r.kind)
      ROW_AW: begin
        drive_aw(r);
        @(negedge clk);
        acc_cycle = cycle_cnt;
      end
      ROW_B: begin
        gap = int'($urandom % 4);
        idle_cycles(gap);
        drive_b(r);
      end
      ROW_IDLE: begin
      end
      ROW_CLEAR: begin
        drive_clear();
      end
      ROW_TIMEOUT: begin
        lim  = limit_ticks(int'(r.len));
        lo   = (lim - 1) * PrescalerDiv;
        hi   = lim * PrescalerDiv + 3;
        seen = 1'b0;
        while (!seen) begin
          @(negedge clk);
          if (reset_req === 1'b1) begin
            seen = 1'b1;
          end else if (cycle_cnt - acc_cycle > hi) begin
            abort_run("Reset request did not arrive within the budget window");
          end
        end
        check_val(32'(cycle_cnt - acc_cycle < lo), 0, "reset_req_o before lower bound");
        timeouts_exp++;
      end
      ROW_SURVIVE: begin
        // Past the latest timeout point of the shorter write
        hi = limit_ticks(int'(r.len)) * PrescalerDiv + 3;
        while (cycle_cnt - acc_cycle <= hi) begin
          @(negedge clk);
        end
      end
      default: begin
        abort_run("Stimulus table holds an unknown row kind");
      end
    endcase
    idle_cycles(int'(r.wait_cyc));
    @(negedge clk);
    check_val(32'(txn_count), 32'(r.exp_count), "txn_count_o");
    check_val(32'(reset_req), 32'(r.exp_reset), "reset_req_o");
    check_val(32'(irq_seen), 32'(timeouts_exp), "irq_o pulse count");
    check_val(32'(uut.i_checker.any_fail), 0, "checker assertion flag");
  endtask

  initial begin
    int wait_sum;
    void'($urandom(12411));
    clk          = 1'b0;
    rst_n        = 1'b0;
    wr_en        = 1'b1;
    aw_valid     = 1'b0;
    aw_ready     = 1'b0;
    aw_id        = '0;
    aw_len       = '0;
    b_valid      = 1'b0;
    b_ready      = 1'b0;
    b_id         = '0;
    budget       = guard_types_pkg::budget_t'(Budget);
    reset_clear  = 1'b0;
    cycle_cnt    = 0;
    acc_cycle    = 0;
    irq_seen     = 0;
    timeouts_exp = 0;

    build_table();
    wait_sum = 0;
    foreach (rows[i]) begin
      wait_sum += int'(rows[i].wait_cyc);
    end
    cycle_limit = ResetCycles + wait_sum + CycleSlack;

    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val(32'(reset_req), 0, "reset_req_o after reset");
    check_val(32'(irq), 0, "irq_o after reset");
    check_val(32'(txn_count), 0, "txn_count_o after reset");

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/guard_cfg_pkg.sv ====
// Write guard configuration package
// Bus field widths and default sizing of the transaction table

`default_nettype none

package guard_cfg_pkg;

  // Bus field widths
  localparam int unsigned IdWidth     = 4;
  localparam int unsigned LenWidth    = 8;
  localparam int unsigned BudgetWidth = 3;

  // Default table depth
  localparam int unsigned DefaultMaxWrTxns = 4;

  // Cycles per age tick, power of two
  localparam int unsigned DefaultPrescalerDiv = 2;

  // Age counter width, must hold the largest limit
  localparam int unsigned DefaultCntWidth = 6;

endpackage

`default_nettype wire

// ==== verilog/guard_prescaler.sv ====
// Age tick prescaler
// One-cycle tick every PrescalerDiv clock cycles

`timescale 1ns/1ps
`default_nettype none

module guard_prescaler #(
  parameter int unsigned PrescalerDiv = guard_cfg_pkg::DefaultPrescalerDiv
) (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic tick_o
);

  // One bit minimum so a divide by one still has a counter
  localparam int unsigned DivWidth = (PrescalerDiv > 1) ? $clog2(PrescalerDiv) : 1;
  localparam logic [DivWidth-1:0] LastCnt = DivWidth'(PrescalerDiv - 1);

  logic [DivWidth-1:0] div_cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_cnt_q <= '0;
    end else if (div_cnt_q == LastCnt) begin
      div_cnt_q <= '0;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // Stays high when the counter never leaves zero
  assign tick_o = (div_cnt_q == LastCnt);

endmodule

`default_nettype wire

// ==== verilog/guard_types_pkg.sv ====
// Write guard type package
// Bus field types, controller state enum and table opcode enum

`default_nettype none

package guard_types_pkg;

  // Bus fields
  typedef logic [guard_cfg_pkg::IdWidth-1:0]     id_t;
  typedef logic [guard_cfg_pkg::LenWidth-1:0]    len_t;
  typedef logic [guard_cfg_pkg::BudgetWidth-1:0] budget_t;

  // Controller states
  typedef enum logic [1:0] {
    GUARD_IDLE  = 2'd0,
    GUARD_TRACK = 2'd1,
    GUARD_RESET = 2'd2
  } guard_state_e;

  // Commands from the controller to the transaction table
  typedef enum logic [1:0] {
    TBL_NOP    = 2'd0,
    TBL_ALLOC  = 2'd1,
    TBL_RETIRE = 2'd2,
    TBL_FLUSH  = 2'd3
  } tbl_op_e;

endpackage

`default_nettype wire

// ==== verilog/id_match_unit.sv ====
// Transaction table lookup
// ID match with one-hot to binary encode, lowest free entry search, full flag

`timescale 1ns/1ps
`default_nettype none

module id_match_unit #(
  parameter int unsigned MaxWrTxns = guard_cfg_pkg::DefaultMaxWrTxns,
  localparam int unsigned IdxWidth = (MaxWrTxns > 1) ? $clog2(MaxWrTxns) : 1
) (
  input  guard_types_pkg::id_t [MaxWrTxns-1:0] entry_id_i,
  input  logic [MaxWrTxns-1:0]                 entry_valid_i,
  input  guard_types_pkg::id_t                 match_id_i,
  output logic                                 hit_o,
  output logic [IdxWidth-1:0]                  match_idx_o,
  output logic [IdxWidth-1:0]                  free_idx_o,
  output logic                                 full_o
);

  logic [MaxWrTxns-1:0] hit_vec;

  // Per-entry compare, only valid entries count
  always_comb begin
    for (int unsigned i = 0; i < MaxWrTxns; i++) begin
      hit_vec[i] = entry_valid_i[i] && (entry_id_i[i] == match_id_i);
    end
  end

  // At most one hit since IDs are unique in the table
  always_comb begin
    match_idx_o = '0;
    for (int unsigned i = 0; i < MaxWrTxns; i++) begin
      if (hit_vec[i]) begin
        match_idx_o = match_idx_o | IdxWidth'(i);
      end
    end
  end

  // Walk downwards so the lowest free entry wins
  always_comb begin
    free_idx_o = '0;
    for (int i = MaxWrTxns - 1; i >= 0; i--) begin
      if (!entry_valid_i[i]) begin
        free_idx_o = IdxWidth'(i);
      end
    end
  end

  assign hit_o  = |hit_vec;
  assign full_o = &entry_valid_i;

endmodule

`default_nettype wire

// ==== verilog/txn_table.sv ====
// Outstanding write transaction table
// Entry registers, age counters, alloc/retire/flush, timeout and count

`timescale 1ns/1ps
`default_nettype none

module txn_table #(
  parameter int unsigned MaxWrTxns = guard_cfg_pkg::DefaultMaxWrTxns,
  parameter int unsigned CntWidth  = guard_cfg_pkg::DefaultCntWidth
) (
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    tick_i,
  txn_tbl_if.tbl tbl
);

  localparam int unsigned IdxWidth   = (MaxWrTxns > 1) ? $clog2(MaxWrTxns) : 1;
  localparam int unsigned CountWidth = $clog2(MaxWrTxns + 1);

  typedef logic [CntWidth-1:0] age_t;

  // Entry state
  logic [MaxWrTxns-1:0]                 valid_q;
  guard_types_pkg::id_t [MaxWrTxns-1:0] id_q;
  age_t                                 limit_q [MaxWrTxns];
  age_t                                 age_q   [MaxWrTxns];

  logic [MaxWrTxns-1:0]  limit_hit;
  logic [IdxWidth-1:0]   match_idx;
  logic [IdxWidth-1:0]   free_idx;
  logic [CountWidth-1:0] valid_cnt;
  logic [CountWidth-1:0] count_q;
  logic                  alloc_en;
  logic                  retire_en;
  logic                  flush_en;

  id_match_unit #(
    .MaxWrTxns ( MaxWrTxns )
  ) i_id_match (
    .entry_id_i    ( id_q          ),
    .entry_valid_i ( valid_q       ),
    .match_id_i    ( tbl.retire_id ),
    .hit_o         ( tbl.hit       ),
    .match_idx_o   ( match_idx     ),
    .free_idx_o    ( free_idx      ),
    .full_o        ( tbl.full      )
  );

  assign alloc_en  = (tbl.op == guard_types_pkg::TBL_ALLOC);
  assign retire_en = (tbl.op == guard_types_pkg::TBL_RETIRE);
  assign flush_en  = (tbl.op == guard_types_pkg::TBL_FLUSH);

  // Valid bits, controller never sends two ops at once
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_en) begin
      valid_q <= '0;
    end else if (alloc_en) begin
      valid_q[free_idx] <= 1'b1;
    end else if (retire_en) begin
      valid_q[match_idx] <= 1'b0;
    end
  end

  // Entry payload and ageing
  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < MaxWrTxns; i++) begin
      if (alloc_en && (free_idx == IdxWidth'(i))) begin
        id_q[i]    <= tbl.alloc_id;
        limit_q[i] <= tbl.alloc_limit;
        age_q[i]   <= '0;
      end else if (tick_i && valid_q[i] && !limit_hit[i]) begin
        age_q[i] <= age_q[i] + 1'b1;   // saturates at the limit
      end
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < MaxWrTxns; i++) begin
      limit_hit[i] = valid_q[i] && (age_q[i] == limit_q[i]);
    end
  end

  assign tbl.timeout = |limit_hit;

  // Population count of valid entries
  always_comb begin
    valid_cnt = '0;
    for (int unsigned i = 0; i < MaxWrTxns; i++) begin
      valid_cnt = valid_cnt + CountWidth'(valid_q[i]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      count_q <= valid_cnt;
    end
  end

  assign tbl.count = count_q;

endmodule

`default_nettype wire

// ==== verilog/txn_tbl_if.sv ====
// Controller to transaction table interface
// Command side (ctrl) and status side (tbl) modports

`timescale 1ns/1ps
`default_nettype none

interface txn_tbl_if #(
  parameter int unsigned MaxWrTxns = guard_cfg_pkg::DefaultMaxWrTxns,
  parameter int unsigned CntWidth  = guard_cfg_pkg::DefaultCntWidth
);

  localparam int unsigned CountWidth = $clog2(MaxWrTxns + 1);

  // Command, one per cycle at most
  guard_types_pkg::tbl_op_e op;
  guard_types_pkg::id_t     alloc_id;
  logic [CntWidth-1:0]      alloc_limit;
  guard_types_pkg::id_t     retire_id;

  // Status
  logic                     hit;
  logic                     full;
  logic                     timeout;
  logic [CountWidth-1:0]    count;   // Registered number of valid entries

  modport ctrl (
    output op,
    output alloc_id,
    output alloc_limit,
    output retire_id,
    input  hit,
    input  full,
    input  timeout,
    input  count
  );

  modport tbl (
    input  op,
    input  alloc_id,
    input  alloc_limit,
    input  retire_id,
    output hit,
    output full,
    output timeout,
    output count
  );

endinterface

`default_nettype wire

// ==== verilog/write_guard_ctrl.sv ====
// Write guard controller
// FSM, handshake to table op decode, deferred AW, budget limit, reset and irq

`timescale 1ns/1ps
`default_nettype none

module write_guard_ctrl #(
  parameter int unsigned PrescalerDiv = guard_cfg_pkg::DefaultPrescalerDiv
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              wr_en_i,
  input  logic                              aw_valid_i,
  input  logic                              aw_ready_i,
  input  guard_types_pkg::id_t              aw_id_i,
  input  guard_types_pkg::len_t             aw_len_i,
  input  logic                              b_valid_i,
  input  logic                              b_ready_i,
  input  guard_types_pkg::id_t              b_id_i,
  input  guard_types_pkg::budget_t          budget_i,
  input  logic                              reset_clear_i,
  output logic                              reset_req_o,
  output logic                              irq_o,
  txn_tbl_if.ctrl                           tbl
);

  localparam int unsigned LimitWidth = tbl.CntWidth;
  localparam int unsigned PreShift   = $clog2(PrescalerDiv);

  typedef logic [LimitWidth-1:0] limit_t;

  guard_types_pkg::guard_state_e state_q;
  guard_types_pkg::guard_state_e state_d;

  logic                              aw_acc;
  logic                              b_acc;
  logic                              do_retire;
  logic                              active;
  logic [guard_cfg_pkg::LenWidth:0]  beats;
  limit_t                            aw_limit;

  // Deferred AW, one deep
  logic                              hold_valid_q;
  guard_types_pkg::id_t              hold_id_q;
  limit_t                            hold_limit_q;

  logic                              irq_q;

  assign aw_acc    = aw_valid_i && aw_ready_i && wr_en_i;
  assign b_acc     = b_valid_i && b_ready_i;
  assign active    = (state_q != guard_types_pkg::GUARD_RESET);
  assign do_retire = b_acc && tbl.hit;

  // Budget base plus prescaled beat count plus one tick of slack
  assign beats    = {1'b0, aw_len_i} + 1'b1;
  assign aw_limit = LimitWidth'(budget_i) + LimitWidth'(beats >> PreShift) + 1'b1;

  assign tbl.retire_id = b_id_i;

  // Op decode, priority flush > retire > new AW > held AW
  always_comb begin
    tbl.op          = guard_types_pkg::TBL_NOP;
    tbl.alloc_id    = aw_id_i;
    tbl.alloc_limit = aw_limit;
    if (!aw_acc) begin
      tbl.alloc_id    = hold_id_q;
      tbl.alloc_limit = hold_limit_q;
    end
    if (active) begin
      if (tbl.timeout) begin
        tbl.op = guard_types_pkg::TBL_FLUSH;
      end else if (do_retire) begin
        tbl.op = guard_types_pkg::TBL_RETIRE;
      end else if (aw_acc) begin
        if (!tbl.full) begin
          tbl.op = guard_types_pkg::TBL_ALLOC;
        end
      end else if (hold_valid_q && !b_acc && !tbl.full) begin
        tbl.op = guard_types_pkg::TBL_ALLOC;
      end
    end
  end

  // AW that collides with a retire waits one cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_valid_q <= 1'b0;
    end else begin
      hold_valid_q <= active && !tbl.timeout && do_retire && aw_acc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_acc) begin
      hold_id_q    <= aw_id_i;
      hold_limit_q <= aw_limit;
    end
  end

  // State follows the registered table count
  always_comb begin
    state_d = state_q;
    case (state_q)
      guard_types_pkg::GUARD_IDLE: begin
        if (tbl.timeout) begin
          state_d = guard_types_pkg::GUARD_RESET;
        end else if (tbl.count != '0) begin
          state_d = guard_types_pkg::GUARD_TRACK;
        end
      end
      guard_types_pkg::GUARD_TRACK: begin
        if (tbl.timeout) begin
          state_d = guard_types_pkg::GUARD_RESET;
        end else if (tbl.count == '0) begin
          state_d = guard_types_pkg::GUARD_IDLE;
        end
      end
      guard_types_pkg::GUARD_RESET: begin
        if (reset_clear_i) begin
          state_d = guard_types_pkg::GUARD_IDLE;
        end
      end
      default: state_d = guard_types_pkg::GUARD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= guard_types_pkg::GUARD_IDLE;
      irq_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      irq_q   <= active && tbl.timeout;
    end
  end

  // Request held for as long as the FSM sits in reset
  assign reset_req_o = (state_q == guard_types_pkg::GUARD_RESET);
  assign irq_o       = irq_q;

endmodule

`default_nettype wire

// ==== verilog/write_guard_top.sv ====
// Write guard top level
// Prescaler, transaction table and controller joined by txn_tbl_if

`timescale 1ns/1ps
`default_nettype none

module write_guard_top #(
  parameter int unsigned MaxWrTxns    = guard_cfg_pkg::DefaultMaxWrTxns,
  parameter int unsigned PrescalerDiv = guard_cfg_pkg::DefaultPrescalerDiv,
  parameter int unsigned CntWidth     = guard_cfg_pkg::DefaultCntWidth
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               wr_en_i,
  input  logic                               aw_valid_i,
  input  logic                               aw_ready_i,
  input  guard_types_pkg::id_t               aw_id_i,
  input  guard_types_pkg::len_t              aw_len_i,
  input  logic                               b_valid_i,
  input  logic                               b_ready_i,
  input  guard_types_pkg::id_t               b_id_i,
  input  guard_types_pkg::budget_t           budget_i,
  input  logic                               reset_clear_i,
  output logic                               reset_req_o,
  output logic                               irq_o,
  output logic [$clog2(MaxWrTxns + 1)-1:0]   txn_count_o
);

  logic tick;

  txn_tbl_if #(
    .MaxWrTxns ( MaxWrTxns ),
    .CntWidth  ( CntWidth  )
  ) tbl_if ();

  guard_prescaler #(
    .PrescalerDiv ( PrescalerDiv )
  ) i_prescaler (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .tick_o  ( tick    )
  );

  txn_table #(
    .MaxWrTxns ( MaxWrTxns ),
    .CntWidth  ( CntWidth  )
  ) i_txn_table (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .tick_i  ( tick       ),
    .tbl     ( tbl_if.tbl )
  );

  write_guard_ctrl #(
    .PrescalerDiv ( PrescalerDiv )
  ) i_ctrl (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .wr_en_i       ( wr_en_i       ),
    .aw_valid_i    ( aw_valid_i    ),
    .aw_ready_i    ( aw_ready_i    ),
    .aw_id_i       ( aw_id_i       ),
    .aw_len_i      ( aw_len_i      ),
    .b_valid_i     ( b_valid_i     ),
    .b_ready_i     ( b_ready_i     ),
    .b_id_i        ( b_id_i        ),
    .budget_i      ( budget_i      ),
    .reset_clear_i ( reset_clear_i ),
    .reset_req_o   ( reset_req_o   ),
    .irq_o         ( irq_o         ),
    .tbl           ( tbl_if.ctrl   )
  );

  assign txn_count_o = tbl_if.count;

endmodule

`default_nettype wire
